/* hdl/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;
  localparam int strb_w = 4;
  localparam logic [xlen-1:0] reset_pc = '0;

  // major opcodes of RV32I
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_auipc  = 7'b0010111,
    opc_lui    = 7'b0110111,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // values follow funct3 of the branch encodings
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_none = 3'b010,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {size_byte = 2'b00, size_half = 2'b01, size_word = 2'b10} mem_size_e;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halted
  } core_state_e;

endpackage

/* hdl/rv_regfile.sv */
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]       rd_data
);

  logic [rv_pkg::xlen-1:0] regs [rv_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_decoder.sv */
module rv_decoder (
  input  logic [rv_pkg::xlen-1:0]       insn,
  output rv_pkg::opcode_e               opcode,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       imm,
  output rv_pkg::alu_op_e               alu_op,
  output logic                          src_pc,
  output logic                          src_imm,
  output rv_pkg::br_cond_e              br_cond,
  output rv_pkg::mem_size_e             mem_size,
  output logic                          load_unsigned,
  output logic                          illegal
);

  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic [rv_pkg::xlen-1:0] imm_u;

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign rd = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1 = insn[19:15];
  assign rs2 = insn[24:20];
  assign funct7 = insn[31:25];

  // sign-extended immediates per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'd0};

  assign mem_size = rv_pkg::mem_size_e'(funct3[1:0]);
  assign load_unsigned = funct3[2];

  always_comb begin
    imm = '0;
    alu_op = rv_pkg::alu_add;
    src_pc = 1'b0;
    src_imm = 1'b1;
    br_cond = rv_pkg::br_none;
    illegal = 1'b0;
    case (opcode)
      rv_pkg::opc_lui: begin
        imm = imm_u;
        alu_op = rv_pkg::alu_pass_b;
      end
      rv_pkg::opc_auipc: begin
        imm = imm_u;
        src_pc = 1'b1;
      end
      rv_pkg::opc_jal: imm = imm_j;
      rv_pkg::opc_jalr: begin
        imm = imm_i;
        illegal = (funct3 != 3'b000);
      end
      rv_pkg::opc_branch: begin
        imm = imm_b;
        src_imm = 1'b0;
        br_cond = rv_pkg::br_cond_e'(funct3);
        // 010 and 011 are not branches
        illegal = (funct3[2:1] == 2'b01);
      end
      rv_pkg::opc_load: begin
        imm = imm_i;
        illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv_pkg::opc_store: begin
        imm = imm_s;
        illegal = (funct3 > 3'b010);
      end
      rv_pkg::opc_op_imm, rv_pkg::opc_op: begin
        if (opcode == rv_pkg::opc_op_imm) begin
          imm = imm_i;
        end else begin
          src_imm = 1'b0;
        end
        case (funct3)
          3'b000: alu_op = (src_imm || !funct7[5]) ? rv_pkg::alu_add : rv_pkg::alu_sub;
          3'b001: alu_op = rv_pkg::alu_sll;
          3'b010: alu_op = rv_pkg::alu_slt;
          3'b011: alu_op = rv_pkg::alu_sltu;
          3'b100: alu_op = rv_pkg::alu_xor;
          3'b101: alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          3'b110: alu_op = rv_pkg::alu_or;
          default: alu_op = rv_pkg::alu_and;
        endcase
        // funct7 is checked for shifts and for every register-register op
        if (!src_imm || funct3 == 3'b001 || funct3 == 3'b101) begin
          illegal = !(funct7 == 7'd0 || (funct7 == 7'b0100000 &&
                      (funct3 == 3'b101 || (!src_imm && funct3 == 3'b000))));
        end
      end
      rv_pkg::opc_system: illegal = (insn[31:7] != 25'd0);
      default: illegal = 1'b1;
    endcase
  end

endmodule

/* hdl/rv_alu.sv */
module rv_alu (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::core_state_e     state,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic                    src_pc,
  input  logic                    src_imm,
  input  rv_pkg::alu_op_e         alu_op,
  input  rv_pkg::br_cond_e        br_cond,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    branch_taken
);

  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] op_b;
  logic [4:0]              shamt;
  logic [rv_pkg::xlen-1:0] alu_out;

  assign op_a = src_pc ? pc : rs1_data;
  assign op_b = src_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:    alu_out = op_a + op_b;
      rv_pkg::alu_sub:    alu_out = op_a - op_b;
      rv_pkg::alu_sll:    alu_out = op_a << shamt;
      rv_pkg::alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu:   alu_out = {31'd0, op_a < op_b};
      rv_pkg::alu_xor:    alu_out = op_a ^ op_b;
      rv_pkg::alu_srl:    alu_out = op_a >> shamt;
      rv_pkg::alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::alu_or:     alu_out = op_a | op_b;
      rv_pkg::alu_and:    alu_out = op_a & op_b;
      default:            alu_out = op_b;
    endcase
  end

  // result held from execute through writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (state == rv_pkg::st_execute) begin
      result <= alu_out;
    end
  end

  always_comb begin
    case (br_cond)
      rv_pkg::br_beq:  branch_taken = (rs1_data == rs2_data);
      rv_pkg::br_bne:  branch_taken = (rs1_data != rs2_data);
      rv_pkg::br_blt:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::br_bge:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::br_bltu: branch_taken = (rs1_data < rs2_data);
      rv_pkg::br_bgeu: branch_taken = (rs1_data >= rs2_data);
      default:         branch_taken = 1'b0;
    endcase
  end

endmodule

/* hdl/rv_lsu.sv */
module rv_lsu (
  input  logic                      clk,
  input  logic                      rst,
  input  rv_pkg::core_state_e       state,
  input  logic [rv_pkg::xlen-1:0]   addr,
  input  logic [rv_pkg::xlen-1:0]   rs2_data,
  input  rv_pkg::mem_size_e         mem_size,
  input  logic                      load_unsigned,
  input  logic                      store_en,
  output logic [rv_pkg::xlen-1:0]   dmem_addr,
  output logic [rv_pkg::xlen-1:0]   dmem_wdata,
  output logic [rv_pkg::strb_w-1:0] dmem_wstrb,
  input  logic [rv_pkg::xlen-1:0]   dmem_rdata,
  output logic [rv_pkg::xlen-1:0]   load_data
);

  logic [rv_pkg::strb_w-1:0] lane_strb;
  logic [rv_pkg::xlen-1:0]   shifted;
  logic [rv_pkg::xlen-1:0]   load_ext;

  assign dmem_addr = {addr[rv_pkg::xlen-1:2], 2'b00};

  // store data is replicated, the strobes pick the lane
  always_comb begin
    case (mem_size)
      rv_pkg::size_byte: begin
        dmem_wdata = {4{rs2_data[7:0]}};
        lane_strb = 4'b0001 << addr[1:0];
      end
      rv_pkg::size_half: begin
        dmem_wdata = {2{rs2_data[15:0]}};
        lane_strb = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = rs2_data;
        lane_strb = 4'b1111;
      end
    endcase
  end

  assign dmem_wstrb = store_en ? lane_strb : '0;

  // addressed byte or half moved down to bit 0
  assign shifted = dmem_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (mem_size)
      rv_pkg::size_byte: load_ext = {{24{shifted[7] & ~load_unsigned}}, shifted[7:0]};
      rv_pkg::size_half: load_ext = {{16{shifted[15] & ~load_unsigned}}, shifted[15:0]};
      default:           load_ext = dmem_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      load_data <= '0;
    end else if (state == rv_pkg::st_memory) begin
      load_data <= load_ext;
    end
  end

endmodule

/* hdl/rv_control.sv */
module rv_control (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [rv_pkg::xlen-1:0]          imem_rdata,
  input  rv_pkg::opcode_e                  opcode,
  input  logic                             illegal,
  input  logic [rv_pkg::xlen-1:0]          imm,
  input  logic [rv_pkg::reg_addr_w-1:0]    rd,
  input  logic [rv_pkg::xlen-1:0]          alu_result,
  input  logic                             branch_taken,
  input  logic [rv_pkg::xlen-1:0]          load_data,
  output rv_pkg::core_state_e              state,
  output logic [rv_pkg::xlen-1:0]          pc,
  output logic [rv_pkg::xlen-1:0]          insn,
  output logic                             store_en,
  output logic                             rd_we,
  output logic [rv_pkg::xlen-1:0]          rd_wdata,
  output logic                             halt,
  output logic                             retire_valid,
  output logic [rv_pkg::xlen-1:0]          retire_pc,
  output logic [rv_pkg::xlen-1:0]          retire_insn,
  output logic [rv_pkg::reg_addr_w-1:0]    retire_rd,
  output logic [rv_pkg::xlen-1:0]          retire_data
);

  logic                    writes_rd;
  logic                    is_jump;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] next_pc;

  assign pc_plus4 = pc + 32'd4;
  assign is_jump = (opcode == rv_pkg::opc_jal) || (opcode == rv_pkg::opc_jalr);
  assign writes_rd = !((opcode == rv_pkg::opc_store) || (opcode == rv_pkg::opc_branch) ||
                       (opcode == rv_pkg::opc_system));

  // jalr target comes out of the alu as rs1 + imm
  always_comb begin
    next_pc = pc_plus4;
    if (opcode == rv_pkg::opc_jalr) begin
      next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
    end else if (opcode == rv_pkg::opc_jal || branch_taken) begin
      next_pc = pc + imm;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::st_fetch;
      pc <= rv_pkg::reset_pc;
    end else begin
      case (state)
        rv_pkg::st_fetch:     state <= rv_pkg::st_decode;
        rv_pkg::st_decode:    state <= illegal ? rv_pkg::st_halted : rv_pkg::st_execute;
        rv_pkg::st_execute:   state <= rv_pkg::st_memory;
        rv_pkg::st_memory:    state <= rv_pkg::st_writeback;
        rv_pkg::st_writeback: begin
          pc <= next_pc;
          // ecall retires, then parks the core
          state <= (opcode == rv_pkg::opc_system) ? rv_pkg::st_halted : rv_pkg::st_fetch;
        end
        default:              state <= rv_pkg::st_halted;
      endcase
    end
  end

  // instruction register, loaded at the end of fetch
  always_ff @(posedge clk) begin
    if (state == rv_pkg::st_fetch) begin
      insn <= imem_rdata;
    end
  end

  assign store_en = (state == rv_pkg::st_memory) && (opcode == rv_pkg::opc_store);
  assign rd_we = (state == rv_pkg::st_writeback) && writes_rd;

  assign rd_wdata = (opcode == rv_pkg::opc_load) ? load_data :
                    is_jump ? pc_plus4 : alu_result;

  assign halt = (state == rv_pkg::st_halted);
  assign retire_valid = (state == rv_pkg::st_writeback);
  assign retire_pc = pc;
  assign retire_insn = insn;
  assign retire_rd = writes_rd ? rd : '0;
  assign retire_data = writes_rd ? rd_wdata : '0;

endmodule

/* hdl/rv_core.sv */
module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  output logic [rv_pkg::xlen-1:0]       imem_addr,
  input  logic [rv_pkg::xlen-1:0]       imem_rdata,
  output logic [rv_pkg::xlen-1:0]       dmem_addr,
  output logic [rv_pkg::xlen-1:0]       dmem_wdata,
  output logic [rv_pkg::strb_w-1:0]     dmem_wstrb,
  input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
  output logic                          halt,
  output logic                          retire_valid,
  output logic [rv_pkg::xlen-1:0]       retire_pc,
  output logic [rv_pkg::xlen-1:0]       retire_insn,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data
);

  rv_pkg::core_state_e           state;
  rv_pkg::opcode_e               opcode;
  rv_pkg::alu_op_e               alu_op;
  rv_pkg::br_cond_e              br_cond;
  rv_pkg::mem_size_e             mem_size;
  logic [rv_pkg::xlen-1:0]       pc, insn, imm, alu_result, load_data;
  logic [rv_pkg::xlen-1:0]       rs1_data, rs2_data, rd_wdata;
  logic [rv_pkg::reg_addr_w-1:0] rd, rs1, rs2;
  logic                          illegal, branch_taken, store_en, rd_we;
  logic                          src_pc, src_imm, load_unsigned;

  assign imem_addr = pc;

  rv_control i_rv_control (
    .clk, .rst, .imem_rdata, .opcode, .illegal, .imm, .rd, .alu_result, .branch_taken,
    .load_data, .state, .pc, .insn, .store_en, .rd_we, .rd_wdata, .halt, .retire_valid,
    .retire_pc, .retire_insn, .retire_rd, .retire_data
  );

  rv_decoder i_rv_decoder (
    .insn, .opcode, .rd, .rs1, .rs2, .imm, .alu_op, .src_pc, .src_imm, .br_cond,
    .mem_size, .load_unsigned, .illegal
  );

  rv_regfile i_rv_regfile (
    .clk, .rst, .rs1, .rs2, .rs1_data, .rs2_data, .we(rd_we), .rd, .rd_data(rd_wdata)
  );

  rv_alu i_rv_alu (
    .clk, .rst, .state, .pc, .rs1_data, .rs2_data, .imm, .src_pc, .src_imm, .alu_op,
    .br_cond, .result(alu_result), .branch_taken
  );

  // effective address is the registered alu sum
  rv_lsu i_rv_lsu (
    .clk, .rst, .state, .addr(alu_result), .rs2_data, .mem_size, .load_unsigned,
    .store_en, .dmem_addr, .dmem_wdata, .dmem_wstrb, .dmem_rdata, .load_data
  );

endmodule

/* tb/rv_core_asserts.sv */
module rv_core_asserts (
  input logic        clk,
  input logic        rst,
  input logic        halt,
  input logic        retire_valid,
  input logic [3:0]  dmem_wstrb
);

  // one retire per five-cycle instruction
  assert property (@(posedge clk) disable iff (rst) retire_valid |=> !retire_valid)
    else $error("retire_valid high in consecutive cycles");

  // a store writes memory in one cycle only
  assert property (@(posedge clk) disable iff (rst) (dmem_wstrb != 4'd0) |=> (dmem_wstrb == 4'd0))
    else $error("store strobes held for more than one cycle");

  // halted is left only by reset
  assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt fell without reset");

  assert property (@(posedge clk) disable iff (rst) !(halt && retire_valid))
    else $error("retire while halted");

endmodule

bind rv_core rv_core_asserts i_rv_core_asserts (.*);

/* tb/rv_core_tb.sv */
module rv_core_tb;

  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [6:0] opc_reg = 7'b0110011;
  localparam logic [31:0] ecall = 32'h0000_0073;

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic [3:0]  dmem_wstrb;
  logic        halt, retire_valid;
  logic [31:0] retire_pc, retire_insn, retire_data;
  logic [4:0]  retire_rd;

  logic [31:0] mem [256];
  logic [31:0] prog_pc;
  logic [31:0] exp_pc[$], exp_insn[$], exp_data[$], got_pc[$], got_insn[$], got_data[$];
  logic [4:0]  exp_rd[$], got_rd[$];
  int          got_cyc[$];
  int          cyc;
  int          errors;
  int          checks;
  integer      seed;

  rv_core i_rv_core (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // same-cycle memory answers for both ports
  assign imem_rdata = mem[imem_addr[9:2]];
  assign dmem_rdata = mem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (!rst) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) begin
          mem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  // cycle 1 is the first fetch
  always @(negedge clk) begin
    if (rst) begin
      cyc = 0;
    end else begin
      cyc = cyc + 1;
      if (retire_valid) begin
        got_pc.push_back(retire_pc);
        got_insn.push_back(retire_insn);
        got_rd.push_back(retire_rd);
        got_data.push_back(retire_data);
        got_cyc.push_back(cyc);
      end
    end
  end

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {~{8'h5a, idx}, 8'hc3, idx};
  endfunction

  function automatic logic [31:0] sx12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // RV32I integer result; alt selects sub and sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", what, exp, act);
    end
  endtask

  task automatic emit(input logic [31:0] insn, input logic [4:0] rd, input logic [31:0] data);
    mem[prog_pc[9:2]] = insn;
    exp_pc.push_back(prog_pc);
    exp_insn.push_back(insn);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    prog_pc = prog_pc + 4;
  endtask

  // zero words are illegal, so a wrong path halts
  task automatic skip_to(input logic [31:0] addr);
    while (prog_pc < addr) begin
      mem[prog_pc[9:2]] = 32'd0;
      prog_pc = prog_pc + 4;
    end
  endtask

  task automatic begin_test();
    @(posedge clk);
    rst <= 1'b1;
    exp_pc.delete();
    exp_insn.delete();
    exp_rd.delete();
    exp_data.delete();
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i[7:0]);
    end
    prog_pc = 32'd0;
  endtask

  task automatic run_test(input string name);
    int limit;
    int waited;
    limit = 5 * (exp_pc.size() + 1) + 50;
    waited = 0;
    repeat (2) @(posedge clk);
    got_pc.delete();
    got_insn.delete();
    got_rd.delete();
    got_data.delete();
    got_cyc.delete();
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    while (!halt && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!halt) begin
      errors++;
      $display("timeout: %s did not halt within %0d cycles", name, limit);
    end else begin
      repeat (10) @(negedge clk);
      check($sformatf("%s halt held", name), 32'd1, {31'd0, halt});
      check($sformatf("%s retire count", name), exp_pc.size(), got_pc.size());
      for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
        check($sformatf("%s retire %0d pc", name, i), exp_pc[i], got_pc[i]);
        check($sformatf("%s retire %0d insn", name, i), exp_insn[i], got_insn[i]);
        check($sformatf("%s retire %0d rd", name, i), exp_rd[i], got_rd[i]);
        check($sformatf("%s retire %0d data", name, i), exp_data[i], got_data[i]);
        check($sformatf("%s retire %0d cycle", name, i), 5 * (i + 1), got_cyc[i]);
      end
    end
  endtask

  task automatic alu_test();
    logic [11:0] ia, ib, ic, imm;
    logic [31:0] va, vb;
    begin_test();
    ia = $random(seed);
    ib = $random(seed);
    ic = $random(seed);
    va = sx12(ia);
    vb = sx12(ib);
    emit(enc_i(ia, 0, 0, 1, opc_imm), 1, va);
    emit(enc_i(ib, 0, 0, 2, opc_imm), 2, vb);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(0, 2, 1, f[2:0], 3), 3, alu_ref(f[2:0], 1'b0, va, vb));
      imm = (f == 1 || f == 5) ? {7'd0, ic[4:0]} : ic;
      emit(enc_i(imm, 1, f[2:0], 4, opc_imm), 4, alu_ref(f[2:0], 1'b0, va, sx12(imm)));
    end
    emit(enc_r(7'h20, 2, 1, 0, 3), 3, alu_ref(0, 1'b1, va, vb));
    emit(enc_r(7'h20, 2, 1, 5, 3), 3, alu_ref(5, 1'b1, va, vb));
    emit(enc_i({7'h20, ic[4:0]}, 1, 5, 4, opc_imm), 4, alu_ref(5, 1'b1, va, {27'd0, ic[4:0]}));
    // x0 stays zero after a write
    emit(enc_i(12'd5, 1, 0, 0, opc_imm), 0, va + 5);
    emit(enc_r(0, 0, 0, 0, 6), 6, 32'd0);
    emit(ecall, 0, 0);
    run_test("alu");
  endtask

  task automatic jump_test();
    logic [31:0] p;
    begin_test();
    emit({20'habcde, 5'd5, 7'b0110111}, 5, 32'habcd_e000);
    p = prog_pc;
    emit({20'h00012, 5'd6, 7'b0010111}, 6, p + 32'h0001_2000);
    p = prog_pc;
    emit(enc_j(21'd12, 7), 7, p + 4);
    skip_to(p + 12);
    p = prog_pc;
    emit(enc_i(p[11:0] + 12'd13, 0, 0, 9, opc_imm), 9, p + 13);
    emit(enc_i(12'd0, 9, 0, 8, 7'b1100111), 8, p + 8);
    skip_to(p + 12);
    emit(ecall, 0, 0);
    run_test("jump");
  endtask

  // offset 8 leaves an illegal word for a taken branch to step over
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic taken);
    logic [31:0] p;
    p = prog_pc;
    emit(enc_b(13'd8, rs2, rs1, f3), 0, 32'd0);
    if (taken) begin
      skip_to(p + 8);
    end
  endtask

  task automatic branch_test();
    begin_test();
    emit(enc_i(12'hffd, 0, 0, 1, opc_imm), 1, 32'hffff_fffd);
    emit(enc_i(12'd5, 0, 0, 2, opc_imm), 2, 32'd5);
    branch_case(3'd0, 1, 1, 1'b1);
    branch_case(3'd0, 1, 2, 1'b0);
    branch_case(3'd1, 1, 2, 1'b1);
    branch_case(3'd1, 1, 1, 1'b0);
    branch_case(3'd4, 1, 2, 1'b1);
    branch_case(3'd4, 2, 1, 1'b0);
    branch_case(3'd5, 2, 1, 1'b1);
    branch_case(3'd5, 1, 2, 1'b0);
    branch_case(3'd6, 2, 1, 1'b1);
    branch_case(3'd6, 1, 2, 1'b0);
    branch_case(3'd7, 1, 2, 1'b1);
    branch_case(3'd7, 2, 1, 1'b0);
    emit(ecall, 0, 0);
    run_test("branch");
  endtask

  task automatic memory_test();
    logic [31:0] w, w2, b;
    begin_test();
    emit(enc_i(12'h200, 0, 0, 1, opc_imm), 1, 32'h200);
    emit({20'h8badf, 5'd2, 7'b0110111}, 2, 32'h8bad_f000);
    emit(enc_i(12'h70d, 2, 0, 2, opc_imm), 2, 32'h8bad_f70d);
    emit(enc_i(12'h7c3, 0, 0, 3, opc_imm), 3, 32'h7c3);
    emit(enc_s(12'd0, 2, 1, 2), 0, 32'd0);
    emit(enc_s(12'd1, 3, 1, 0), 0, 32'd0);
    emit(enc_s(12'd2, 3, 1, 1), 0, 32'd0);
    emit(enc_s(12'd7, 3, 1, 0), 0, 32'd0);
    w = 32'h07c3_c30d;
    w2 = (fill_word(8'h81) & 32'h00ff_ffff) | 32'hc300_0000;
    for (int k = 0; k < 4; k++) begin
      b = w >> (8 * k);
      emit(enc_i(k[11:0], 1, 0, 4, 7'b0000011), 4, {{24{b[7]}}, b[7:0]});
      emit(enc_i(k[11:0], 1, 4, 4, 7'b0000011), 4, {24'd0, b[7:0]});
    end
    for (int k = 0; k < 4; k += 2) begin
      b = w >> (8 * k);
      emit(enc_i(k[11:0], 1, 1, 4, 7'b0000011), 4, {{16{b[15]}}, b[15:0]});
      emit(enc_i(k[11:0], 1, 5, 4, 7'b0000011), 4, {16'd0, b[15:0]});
    end
    emit(enc_i(12'd0, 1, 2, 4, 7'b0000011), 4, w);
    emit(ecall, 0, 0);
    run_test("memory");
    check("memory word 0x200", w, mem[8'h80]);
    check("memory word 0x204", w2, mem[8'h81]);
  endtask

  task automatic illegal_test();
    begin_test();
    emit(enc_i(12'd1, 0, 0, 1, opc_imm), 1, 32'd1);
    mem[prog_pc[9:2]] = 32'hffff_ffff;
    run_test("illegal");
  endtask

  initial begin
    rst = 1'b1;
    seed = 32'h117d_bc76;
    errors = 0;
    checks = 0;
    alu_test();
    jump_test();
    branch_test();
    memory_test();
    illegal_test();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* filelist.f */
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_control.sv
hdl/rv_core.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module rv_core_tb -o rv_core_sim
out=$(./obj_dir/rv_core_sim || true)
echo "$out"
echo "$out" | grep -q "^NO ERRORS$"
